//--- verilog.f
verilog/divSqrtPkg.sv
verilog/divSqrtCycles.sv
verilog/intPreShift.sv
verilog/divSqrtIter.sv
verilog/divSqrtFsm.sv
verilog/divSqrt.sv
bench/divSqrtTb.sv

//--- run.sh
#!/bin/sh
# Build and run the divSqrt testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module divSqrtTb -f verilog.f -o divSqrtSim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed"
  exit "$status"
fi

./obj_dir/divSqrtSim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation failed"
  exit "$status"
fi

exit 0

//--- bench/divSqrtTb.sv
`default_nettype none

module divSqrtTb import divSqrtPkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int DIVCOPIES = 2;
  // Random operations per floating-point kind, random integer divisions
  localparam int N_FP = 12;
  localparam int N_INT = 24;
  // Directed integer cases plus the stray-start run
  localparam int N_DIRECTED = 7;
  localparam int NUM_OPS = 4 * N_FP + N_INT + N_DIRECTED;
  localparam int TIMEOUT = NUM_OPS * 40 + 100;

  logic       clk = 1'b0;
  logic       rst;
  logic       start;
  divOp_t     op;
  logic       busy;
  logic       done;
  divResult_t res;

  // Rising edges seen so far
  int cycleCount = 0;
  int issued = 0;
  int doneCount = 0;
  logic [31:0] rnd;

  // Outstanding expectations, oldest first
  divResult_t expResQ[$];
  cycles_t    expCycQ[$];
  int         startQ[$];
  string      nameQ[$];

  divSqrt #(
    .DIVCOPIES (DIVCOPIES)
  ) dut_i (
    .clk   (clk),
    .rst   (rst),
    .start (start),
    .op    (op),
    .busy  (busy),
    .done  (done),
    .res   (res)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
  end

  ////////////////////////////////////////////////////////////////////////
  // Helpers and reference model
  ////////////////////////////////////////////////////////////////////////

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1, "stopped at first error");
  endtask

  function automatic logic [31:0] lcgNext(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Hidden one plus upper LCG bits as fraction
  function automatic xword_t randSig(input fmt_t f, input logic [31:0] r);
    if (f == FMT_S) begin
      return {8'b0, 1'b1, r[31:9]};
    end
    return {21'b0, 1'b1, r[31:22]};
  endfunction

  function automatic divOp_t makeOp(input fmt_t f, input logic isSqrt, input logic isInt,
                                    input xword_t a, input xword_t b);
    divOp_t o;
    o.fmt = f;
    o.sqrt = isSqrt;
    o.intDiv = isInt;
    o.a = a;
    o.b = b;
    return o;
  endfunction

  function automatic string kindName(input int k);
    case (k)
      0: return "half div";
      1: return "single div";
      2: return "half sqrt";
      default: return "single sqrt";
    endcase
  endfunction

  function automatic int leadZeros(input xword_t x);
    xword_t v;
    int n;
    v = x;
    n = 0;
    while (n < XLEN && !v[XLEN-1]) begin
      v = v << 1;
      n++;
    end
    return n;
  endfunction

  // Keeps lo*lo <= x < hi*hi, root stays below 2^27
  function automatic logic [63:0] isqrtBisect(input logic [63:0] x);
    logic [63:0] lo;
    logic [63:0] hi;
    logic [63:0] mid;
    lo = 64'd0;
    hi = 64'd1 << 27;
    while (hi - lo > 64'd1) begin
      mid = (lo + hi) >> 1;
      if (mid * mid <= x) begin
        lo = mid;
      end else begin
        hi = mid;
      end
    end
    return lo;
  endfunction

  function automatic divResult_t refModel(input divOp_t o, output cycles_t cyc);
    divResult_t r;
    int nf;
    int bits;
    int n;
    int s;
    logic [63:0] wide;
    logic [63:0] root;
    nf = (o.fmt == FMT_S) ? S_NF : H_NF;
    // Result bits per operation kind
    if (o.intDiv) begin
      bits = leadZeros(o.b) - leadZeros(o.a) + 1;
      if (o.b == '0 || bits < 1) begin
        bits = 1;
      end
    end else if (o.sqrt) begin
      bits = nf + 2;
    end else begin
      bits = nf + 3;
    end
    cyc = cycles_t'((bits + DIVCOPIES - 1) / DIVCOPIES);
    n = int'(cyc) * DIVCOPIES;
    if (o.intDiv) begin
      if (o.b == '0) begin
        r.quotient = '1;
        r.remainder = o.a;
      end else begin
        r.quotient = o.a / o.b;
        r.remainder = o.a % o.b;
      end
    end else if (o.sqrt) begin
      // Largest even shift not above 2n - Nf - 1
      s = 2 * n - nf - 1;
      s = s - (s % 2);
      wide = 64'(o.a) << s;
      root = isqrtBisect(wide);
      r.quotient = xword_t'(root);
      r.remainder = xword_t'(wide - root * root);
    end else begin
      wide = 64'(o.a) << (n - 1);
      r.quotient = xword_t'(wide / 64'(o.b));
      r.remainder = xword_t'(wide % 64'(o.b));
    end
    r.sticky = (r.remainder != '0);
    return r;
  endfunction

  ////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////

  task automatic checkResult(input string name, input divResult_t expected,
                             input divResult_t actual);
    if (actual !== expected) begin
      abortRun($sformatf("MISMATCH %s: expected q=%h r=%h s=%b, actual q=%h r=%h s=%b",
                         name, expected.quotient, expected.remainder, expected.sticky,
                         actual.quotient, actual.remainder, actual.sticky));
    end
  endtask

  task automatic checkCycles(input string name, input cycles_t expected,
                             input cycles_t actual);
    if (actual !== expected) begin
      abortRun($sformatf("MISMATCH %s cycles: expected %0d, actual %0d",
                         name, expected, actual));
    end
  endtask

  // Start to done spans C + 1 edges
  always @(negedge clk) begin
    if (done === 1'b1) begin
      if (expResQ.size() == 0) begin
        abortRun("done pulse arrived with no operation outstanding");
      end else begin
        checkResult(nameQ[0], expResQ[0], res);
        checkCycles(nameQ[0], expCycQ[0] + 6'd1, cycles_t'(cycleCount - startQ[0]));
        void'(expResQ.pop_front());
        void'(expCycQ.pop_front());
        void'(startQ.pop_front());
        void'(nameQ.pop_front());
        doneCount++;
      end
    end
  end

  always @(negedge clk) begin
    if (cycleCount >= TIMEOUT) begin
      abortRun($sformatf("timeout after %0d cycles, DUT never finished", cycleCount));
    end
  end

  ////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////

  // Optional stray start pulsed while the DUT is busy
  task automatic runOp(input string name, input divOp_t o, input logic stray,
                       input divOp_t strayOp);
    divResult_t e;
    cycles_t c;
    e = refModel(o, c);
    while (busy || done) begin
      @(negedge clk);
    end
    op = o;
    start = 1'b1;
    expResQ.push_back(e);
    expCycQ.push_back(c);
    // Next rising edge accepts the start
    startQ.push_back(cycleCount + 1);
    nameQ.push_back(name);
    issued++;
    @(negedge clk);
    start = 1'b0;
    if (stray) begin
      @(negedge clk);
      if (!busy) begin
        abortRun("DUT was not busy when the stray start was pulsed");
      end
      op = strayOp;
      start = 1'b1;
      @(negedge clk);
      start = 1'b0;
    end
    while (!done) begin
      @(negedge clk);
    end
  endtask

  initial begin
    divOp_t o;
    divOp_t stray;
    fmt_t f;
    logic isSqrt;
    logic [31:0] r2;
    rst = 1'b1;
    start = 1'b0;
    op = '0;
    rnd = 32'hb5ea7777;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    if (busy !== 1'b0 || done !== 1'b0) begin
      abortRun("busy or done not low after reset");
    end

    // Half and single divisions, then square roots
    for (int k = 0; k < 4; k++) begin
      f = fmt_t'(k & 1);
      isSqrt = (k >= 2);
      for (int i = 0; i < N_FP; i++) begin
        rnd = lcgNext(rnd);
        o = makeOp(f, isSqrt, 1'b0, randSig(f, rnd), '0);
        if (!isSqrt) begin
          rnd = lcgNext(rnd);
          o.b = randSig(f, rnd);
        end
        runOp($sformatf("%s %0d", kindName(k), i), o, 1'b0, o);
      end
    end

    // Integer divisions with varied operand lengths
    for (int i = 0; i < N_INT; i++) begin
      rnd = lcgNext(rnd);
      r2 = rnd;
      rnd = lcgNext(rnd);
      o = makeOp(FMT_S, 1'b0, 1'b1, r2 >> rnd[26:22], rnd >> rnd[31:27]);
      runOp($sformatf("int div %0d", i), o, 1'b0, o);
    end

    runOp("int a below b", makeOp(FMT_S, 1'b0, 1'b1, 32'd5, 32'd1000), 1'b0, o);
    runOp("int divide by zero", makeOp(FMT_S, 1'b0, 1'b1, 32'hdeadbeef, '0), 1'b0, o);
    runOp("int zero by zero", makeOp(FMT_S, 1'b0, 1'b1, '0, '0), 1'b0, o);
    runOp("int zero dividend", makeOp(FMT_S, 1'b0, 1'b1, '0, 32'd7), 1'b0, o);
    runOp("int full length", makeOp(FMT_S, 1'b0, 1'b1, '1, 32'd1), 1'b0, o);
    runOp("int equal operands",
          makeOp(FMT_S, 1'b0, 1'b1, 32'h12345678, 32'h12345678), 1'b0, o);

    // Stray start must leave the running division alone
    stray = makeOp(FMT_H, 1'b1, 1'b0, 32'h000007ff, '0);
    rnd = lcgNext(rnd);
    o = makeOp(FMT_S, 1'b0, 1'b0, randSig(FMT_S, rnd), 32'h00ffffff);
    runOp("single div stray start", o, 1'b1, stray);

    repeat (4) @(negedge clk);
    if (doneCount == issued && expResQ.size() == 0 && !busy) begin
      $display("TESTS PASSED");
      $finish;
    end else begin
      abortRun($sformatf("%0d operations issued but %0d completed", issued, doneCount));
    end
  end

endmodule

`default_nettype wire

//--- verilog/divSqrt.sv
`default_nettype none

module divSqrt import divSqrtPkg::*; #(
  parameter int DIVCOPIES = 2
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       start,
  input  divOp_t     op,
  output logic       busy,
  output logic       done,
  output divResult_t res
);

  // Quotient length for early termination
  resultBits_t intResultBits;
  logic        divByZero;
  // Iteration cycles and radix-2 steps of the operation
  cycles_t     cycles;
  resultBits_t nSteps;
  // Sequencer strobes
  logic        load;
  logic        step;

  //////////////////////////////////////////////////////////////////////
  // Operation setup, combinational
  //////////////////////////////////////////////////////////////////////

  intPreShift preShift_i (
    .a             (op.a),
    .b             (op.b),
    .intResultBits (intResultBits),
    .divByZero     (divByZero)
  );

  divSqrtCycles #(
    .DIVCOPIES (DIVCOPIES)
  ) cycles_i (
    .fmt           (op.fmt),
    .sqrt          (op.sqrt),
    .intDiv        (op.intDiv),
    .intResultBits (intResultBits),
    .cycles        (cycles)
  );

  // Every cycle retires DIVCOPIES steps
  assign nSteps = cycles * cycles_t'(DIVCOPIES);

  //////////////////////////////////////////////////////////////////////
  // Sequencer and datapath
  //////////////////////////////////////////////////////////////////////

  divSqrtFsm fsm_i (
    .clk    (clk),
    .rst    (rst),
    .start  (start),
    .cycles (cycles),
    .load   (load),
    .step   (step),
    .busy   (busy),
    .done   (done)
  );

  divSqrtIter #(
    .DIVCOPIES (DIVCOPIES)
  ) iter_i (
    .clk       (clk),
    .rst       (rst),
    .load      (load),
    .step      (step),
    .op        (op),
    .nSteps    (nSteps),
    .divByZero (divByZero),
    .res       (res)
  );

endmodule

`default_nettype wire

//--- verilog/divSqrtFsm.sv
`default_nettype none

module divSqrtFsm import divSqrtPkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  logic    start,
  input  cycles_t cycles,
  output logic    load,
  output logic    step,
  output logic    busy,
  output logic    done
);

  seqState_t state;
  // Iteration cycles still to run
  cycles_t   count;

  //////////////////////////////////////////////////////////////////////
  // Sequencer
  //////////////////////////////////////////////////////////////////////

  // Count reaches zero after the last step
  // One more busy cycle, then DONE
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
      count <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (start) begin
            state <= BUSY;
            count <= cycles;
          end
        end
        BUSY: begin
          if (count == '0) begin
            state <= DONE;
          end else begin
            count <= count - 6'd1;
          end
        end
        DONE: begin
          state <= IDLE;
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // Start only counts while idle
  assign load = (state == IDLE) && start;
  assign step = (state == BUSY) && (count != '0);

  assign busy = (state == BUSY);
  assign done = (state == DONE);

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  assert property (@(posedge clk) disable iff (rst) !(busy && done))
    else $error("divSqrtFsm: busy and done together");

  // Single-cycle done pulse
  assert property (@(posedge clk) disable iff (rst) done |=> !done)
    else $error("divSqrtFsm: done held past one cycle");

endmodule

`default_nettype wire

//--- verilog/divSqrtIter.sv
`default_nettype none

module divSqrtIter import divSqrtPkg::*; #(
  parameter int DIVCOPIES = 2
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        load,
  input  logic        step,
  input  divOp_t      op,
  input  resultBits_t nSteps,
  input  logic        divByZero,
  output divResult_t  res
);

  // Partial remainder width, two spare bits above XLEN
  localparam int REMW = XLEN + 2;
  // Width of the feed register for dividend or radicand bits
  localparam int FEEDW = 2 * XLEN;

  // Datapath registers
  logic [REMW-1:0]  remR;
  xword_t           qR;
  xword_t           divR;
  logic [FEEDW-1:0] feedR;

  // Mode and status flags
  logic loaded;
  logic sqrtR;
  logic firstR;
  logic dbzR;

  // Radicand placement in the feed register
  logic [5:0] radShift;

  // Stage chain, index 0 is the register side
  logic [REMW-1:0]  remS  [DIVCOPIES+1];
  xword_t           qS    [DIVCOPIES+1];
  logic [FEEDW-1:0] feedS [DIVCOPIES+1];

  //////////////////////////////////////////////////////////////////////
  // Radicand alignment
  //////////////////////////////////////////////////////////////////////

  // Shift of 2n - Nf - 1 rounded down to even, left-aligned at 2n bits
  // The n terms cancel, only the parity of Nf + 1 is left
  assign radShift = (op.fmt == FMT_S) ? 6'(FEEDW - S_NF - 1) : 6'(FEEDW - H_NF - 2);

  //////////////////////////////////////////////////////////////////////
  // Restoring stages
  //////////////////////////////////////////////////////////////////////

  assign remS[0]  = remR;
  assign qS[0]    = qR;
  assign feedS[0] = feedR;

  for (genvar k = 0; k < DIVCOPIES; k++) begin : genStage
    logic [REMW-1:0] shifted;
    logic [REMW-1:0] trial;
    logic            skip;
    logic            geq;

    // First FP divide step compares X against Y directly
    assign skip = (k == 0) && firstR;

    always_comb begin
      if (sqrtR) begin
        // Two radicand bits per root bit
        shifted = {remS[k][REMW-3:0], feedS[k][FEEDW-1 -: 2]};
        trial   = {qS[k], 2'b01};
      end else begin
        if (skip) begin
          shifted = remS[k];
        end else begin
          shifted = {remS[k][REMW-2:0], feedS[k][FEEDW-1]};
        end
        trial = {2'b00, divR};
      end
    end

    assign geq = (shifted >= trial);

    // Restore by keeping the unsubtracted value
    assign remS[k+1]  = geq ? shifted - trial : shifted;
    assign qS[k+1]    = {qS[k][XLEN-2:0], geq};
    assign feedS[k+1] = sqrtR ? feedS[k] << 2 : feedS[k] << 1;
  end

  //////////////////////////////////////////////////////////////////////
  // Datapath registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (load) begin
      divR <= op.b;
      qR   <= '0;
      if (op.sqrt) begin
        remR  <= '0;
        feedR <= {{XLEN{1'b0}}, op.a} << radShift;
      end else if (op.intDiv) begin
        // Bits above the last nSteps start in the remainder
        remR  <= {2'b00, op.a >> nSteps};
        feedR <= {op.a << (6'(XLEN) - nSteps), {XLEN{1'b0}}};
      end else begin
        // Significand division brings in zeros only
        remR  <= {2'b00, op.a};
        feedR <= '0;
      end
    end else if (step) begin
      remR  <= remS[DIVCOPIES];
      qR    <= qS[DIVCOPIES];
      feedR <= feedS[DIVCOPIES];
    end
  end

  // Mode flags
  always_ff @(posedge clk) begin
    if (rst) begin
      loaded <= 1'b0;
      sqrtR  <= 1'b0;
      firstR <= 1'b0;
      dbzR   <= 1'b0;
    end else if (load) begin
      loaded <= 1'b1;
      sqrtR  <= op.sqrt;
      firstR <= !op.sqrt && !op.intDiv;
      dbzR   <= op.intDiv && divByZero;
    end else if (step) begin
      firstR <= 1'b0;
    end
  end

  // Zero divisor leaves a in the remainder on its own
  always_comb begin
    res.quotient  = dbzR ? '1 : qR;
    res.remainder = remR[XLEN-1:0];
    res.sticky    = |remR;
  end

  // Sequencer must load before it steps
  assert property (@(posedge clk) disable iff (rst) step |-> loaded)
    else $error("divSqrtIter: step before any load");

endmodule

`default_nettype wire

//--- verilog/intPreShift.sv
`default_nettype none

module intPreShift import divSqrtPkg::*; (
  input  xword_t      a,
  input  xword_t      b,
  output resultBits_t intResultBits,
  output logic        divByZero
);

  // Leading-zero counts of both operands
  resultBits_t lzA;
  resultBits_t lzB;
  // Signed quotient length before clamping
  logic signed [7:0] span;

  //////////////////////////////////////////////////////////////////////
  // Priority leading-zero counter
  //////////////////////////////////////////////////////////////////////

  // Scans upward, so the highest set bit wins
  // All-zero input gives XLEN
  function automatic resultBits_t lzc(input xword_t x);
    resultBits_t n;
    n = resultBits_t'(XLEN);
    for (int i = 0; i < XLEN; i++) begin
      if (x[i]) begin
        n = resultBits_t'(XLEN - 1 - i);
      end
    end
    return n;
  endfunction

  assign lzA = lzc(a);
  assign lzB = lzc(b);

  assign divByZero = (b == '0);

  //////////////////////////////////////////////////////////////////////
  // Quotient length
  //////////////////////////////////////////////////////////////////////

  // Quotient fits in lzB - lzA + 1 bits
  assign span = $signed({2'b00, lzB}) - $signed({2'b00, lzA}) + 8'sd1;

  always_comb begin
    if (divByZero) begin
      // Single pass, quotient is forced later
      intResultBits = 6'd1;
    end else if (span < 8'sd1) begin
      // Dividend below divisor still takes one bit
      intResultBits = 6'd1;
    end else begin
      intResultBits = resultBits_t'(span);
    end
  end

endmodule

`default_nettype wire

//--- verilog/divSqrtCycles.sv
`default_nettype none

module divSqrtCycles import divSqrtPkg::*; #(
  parameter int DIVCOPIES = 2
) (
  input  fmt_t        fmt,
  input  logic        sqrt,
  input  logic        intDiv,
  input  resultBits_t intResultBits,
  output cycles_t     cycles
);

  // Fraction width of the selected format
  resultBits_t nf;
  // Result bits needed by a floating-point operation
  resultBits_t fpBits;
  // Result bits of the operation actually issued
  resultBits_t resultBits;

  always_comb begin
    case (fmt)
      FMT_H:   nf = resultBits_t'(H_NF);
      FMT_S:   nf = resultBits_t'(S_NF);
      default: nf = resultBits_t'(S_NF);
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Result-bit count
  //////////////////////////////////////////////////////////////////////

  // Division needs Nf fraction bits, guard and round, plus one integer bit
  // Square root gets by without the integer bit
  always_comb begin
    if (sqrt) begin
      fpBits = nf + 6'd2;
    end else begin
      fpBits = nf + 6'd3;
    end
    // Integer division terminates early on the quotient length
    resultBits = intDiv ? intResultBits : fpBits;
  end

  // DIVCOPIES bits per clock, so ceil(resultBits / DIVCOPIES)
  assign cycles = cycles_t'((resultBits - 6'd1) / resultBits_t'(DIVCOPIES) + 6'd1);

  // Range check on the count handed to the sequencer
  // Also catches a bad length coming from the integer pre-shift
  always_comb begin
    if (!$isunknown(cycles)) begin
      assert (cycles != '0 && cycles <= 6'd32)
        else $error("divSqrtCycles: cycle count %0d out of range", cycles);
    end
  end

endmodule

`default_nettype wire

//--- verilog/divSqrtPkg.sv
`default_nettype none

package divSqrtPkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////

  // Integer operand width
  localparam int XLEN = 32;

  // Fraction bits of the two supported formats
  localparam int H_NF = 10;
  localparam int S_NF = 23;

  // Format select, one bit with only half and single left
  typedef logic [0:0] fmt_t;
  localparam fmt_t FMT_H = 1'b0;
  localparam fmt_t FMT_S = 1'b1;

  // Operand / result word
  typedef logic [XLEN-1:0] xword_t;

  // Count of result bits, 0 to 32
  typedef logic [5:0] resultBits_t;

  // Iteration cycle count
  typedef logic [5:0] cycles_t;

  //////////////////////////////////////////////////////////////////////
  // Operation and result bundles
  //////////////////////////////////////////////////////////////////////

  // Significands right-aligned, hidden one included
  typedef struct packed {
    fmt_t   fmt;
    logic   sqrt;
    logic   intDiv;
    xword_t a;      // dividend or radicand
    xword_t b;      // divisor
  } divOp_t;

  typedef struct packed {
    xword_t quotient;   // quotient or root
    xword_t remainder;
    logic   sticky;     // remainder nonzero
  } divResult_t;

  // Sequencer states
  typedef enum logic [1:0] {
    IDLE,
    BUSY,
    DONE
  } seqState_t;

endpackage

`default_nettype wire
